/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// format tags, top bits of the word
	localparam logic [2:0] FMT_A_TAG = 3'b110;
	localparam logic       FMT_B_TAG = 1'b0;
	localparam logic [1:0] FMT_C_TAG = 2'b10;
	localparam logic [3:0] FMT_D_TAG = 4'b1110;	// reserved, shares the 4-bit slot with E

	// compare opcodes never write a vector
	localparam logic [1:0] A_CMP_HI2 = 2'b01;	// opcode[5:4]
	localparam logic [3:0] A_CMP_HI4 = 4'b1011;	// opcode[5:2]
	localparam int         B_CMP_BIT = 4;		// b opcode bit

	// format c op types
	localparam logic [3:0] C_OP_BLOCK  = 4'b0111;	// block vector access
	localparam logic [3:0] C_OP_GATHER = 4'b1101;	// scatter/gather from here up

	// offsets are computed with an add
	localparam logic [5:0] ALU_OP_ADD = 6'd5;

	// second operand source, matches execute side
	typedef logic [1:0] op2_src_t;
	localparam op2_src_t OP2_SCALAR = 2'd0;
	localparam op2_src_t OP2_VECTOR = 2'd1;
	localparam op2_src_t OP2_IMM    = 2'd2;

	// mask source
	typedef logic [2:0] mask_src_t;
	localparam mask_src_t MASK_S1     = 3'd0;
	localparam mask_src_t MASK_S1_INV = 3'd1;
	localparam mask_src_t MASK_S2     = 3'd2;
	localparam mask_src_t MASK_S2_INV = 3'd3;
	localparam mask_src_t MASK_ALL    = 3'd4;	// no mask

	// register/register arithmetic
	typedef struct packed {
		logic [2:0] tag;		// 110
		logic [5:0] opcode;
		logic [2:0] a_type;		// scalar/vector combination
		logic [4:0] src2;
		logic [4:0] mask;
		logic [4:0] dest;
		logic [4:0] src1;
	} fmt_a_t;

	// register/immediate arithmetic
	typedef struct packed {
		logic       tag;		// 0
		logic [4:0] opcode;
		logic [1:0] b_type;
		logic [8:0] imm;
		logic [4:0] mask;
		logic [4:0] dest;
		logic [4:0] src1;
	} fmt_b_t;

	// memory access
	typedef struct packed {
		logic [1:0] tag;		// 10
		logic       is_load;
		logic [3:0] op_type;
		logic [9:0] imm;		// address offset
		logic [4:0] mask;
		logic [4:0] dest;		// load dest or store value
		logic [4:0] src1;		// base
	} fmt_c_t;

	// branch style, long immediate
	typedef struct packed {
		logic [3:0]  tag;		// 1110 is D, 1111 is E
		logic [1:0]  rsvd;
		logic [20:0] imm;
		logic [4:0]  src1;
	} fmt_e_t;

	// one word, several views of it
	typedef union packed {
		fmt_a_t fmt_a;
		fmt_b_t fmt_b;
		fmt_c_t fmt_c;
		fmt_e_t fmt_e;
	} instr_word_t;

endpackage

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int REG_ADDR_W = 5;
	localparam int WORD_W     = 32;
	localparam int NUM_LANES  = 16;
	localparam int NUM_REGS   = 1 << REG_ADDR_W;
	localparam int LANE_SEL_W = $clog2(NUM_LANES);

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [NUM_LANES-1:0][WORD_W-1:0] vector_t;	// lane 0 in the low word
	typedef logic [NUM_LANES-1:0] lane_mask_t;
	typedef logic [LANE_SEL_W-1:0] lane_sel_t;

	// what the execute stage gets besides operand values
	typedef struct packed {
		word_t               instruction;
		word_t               pc;
		word_t               immediate;	// already sign extended
		isa_pkg::mask_src_t  mask_src;
		logic                op1_is_vector;
		isa_pkg::op2_src_t   op2_src;
		logic                store_value_is_vector;
		logic                has_writeback;
		reg_addr_t           writeback_reg;
		logic                writeback_is_vector;
		logic [5:0]          alu_op;
		lane_sel_t           lane_select;
	} decoded_t;

	// one write into either file
	typedef struct packed {
		logic       is_vector;		// picks the file
		reg_addr_t  reg_addr;
		lane_mask_t lane_mask;		// vector writes only
		word_t      scalar_value;
		vector_t    vector_value;
	} writeback_t;

endpackage

`default_nettype wire

/* scalar_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module scalar_reg_file
	import core_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n_i,
	input  wire reg_addr_t rd_addr1_i,
	input  wire reg_addr_t rd_addr2_i,
	output word_t          rd_data1_o,
	output word_t          rd_data2_o,
	input  wire            wr_en_i,
	input  wire reg_addr_t wr_addr_i,
	input  wire word_t     wr_data_i
);

	word_t regs [NUM_REGS];	// storage

	// write port
	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			regs[wr_addr_i] <= wr_data_i;
	end

	// registered reads, old value on a same cycle write
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			rd_data1_o <= '0;
			rd_data2_o <= '0;
		end
		else
		begin
			rd_data1_o <= regs[rd_addr1_i];
			rd_data2_o <= regs[rd_addr2_i];
		end
	end

	// a write with an unknown address corrupts the whole file
	a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

`default_nettype wire

/* vector_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_reg_file
	import core_pkg::*;
(
	input  wire             clk,
	input  wire             rst_n_i,
	input  wire reg_addr_t  rd_addr1_i,
	input  wire reg_addr_t  rd_addr2_i,
	output vector_t         rd_data1_o,
	output vector_t         rd_data2_o,
	input  wire             wr_en_i,
	input  wire reg_addr_t  wr_addr_i,
	input  wire lane_mask_t wr_lane_mask_i,
	input  wire vector_t    wr_data_i
);

	vector_t regs [NUM_REGS];	// one full vector per entry

	// lane masked write
	always_ff @(posedge clk)
	begin
		if (wr_en_i)
		begin
			for (int lane = 0; lane < NUM_LANES; lane++)
			begin
				if (wr_lane_mask_i[lane])
					regs[wr_addr_i][lane] <= wr_data_i[lane];	// unmasked lanes keep value
			end
		end
	end

	// read ports, one cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			rd_data1_o <= '0;
			rd_data2_o <= '0;
		end
		else
		begin
			rd_data1_o <= regs[rd_addr1_i];
			rd_data2_o <= regs[rd_addr2_i];
		end
	end

	// an empty mask means the writeback was routed wrong upstream
	a_wr_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
		wr_en_i |-> wr_lane_mask_i != '0);

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
	import isa_pkg::*;
	import core_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n_i,
	input  wire instr_word_t instruction_i,
	input  wire word_t  pc_i,
	input  wire lane_sel_t lane_select_i,
	input  wire         flush_i,
	output reg_addr_t   scalar_sel1_o,
	output reg_addr_t   scalar_sel2_o,
	output reg_addr_t   vector_sel1_o,
	output reg_addr_t   vector_sel2_o,
	output decoded_t    decoded_o
);

	logic       is_fmt_a;
	logic       is_fmt_b;
	logic       is_fmt_c;
	logic       is_fmt_d;
	logic [2:0] a_type;
	logic [1:0] b_type;
	logic [3:0] c_op_type;
	logic [5:0] a_opcode;
	logic [4:0] b_opcode;
	logic       is_vec_xfer;	// block, strided or scatter/gather
	logic       is_scalar_store;
	logic       a_is_compare;
	logic       b_is_compare;
	decoded_t   decoded_nxt;

	assign is_fmt_a = instruction_i.fmt_a.tag == FMT_A_TAG;
	assign is_fmt_b = instruction_i.fmt_b.tag == FMT_B_TAG;
	assign is_fmt_c = instruction_i.fmt_c.tag == FMT_C_TAG;
	assign is_fmt_d = instruction_i.fmt_e.tag == FMT_D_TAG;

	assign a_type    = instruction_i.fmt_a.a_type;
	assign b_type    = instruction_i.fmt_b.b_type;
	assign c_op_type = instruction_i.fmt_c.op_type;
	assign a_opcode  = instruction_i.fmt_a.opcode;
	assign b_opcode  = instruction_i.fmt_b.opcode;

	assign is_vec_xfer     = c_op_type[3] || c_op_type == C_OP_BLOCK;
	assign is_scalar_store = is_fmt_c && !instruction_i.fmt_c.is_load && !is_vec_xfer;
	assign a_is_compare    = a_opcode[5:4] == A_CMP_HI2 || a_opcode[5:2] == A_CMP_HI4;
	assign b_is_compare    = b_opcode[B_CMP_BIT];

	// port selects go out unregistered
	// the files add the cycle, so data lines up with decoded_o
	always_comb
	begin
		scalar_sel1_o = instruction_i.fmt_a.src1;
		if (is_fmt_a && a_type inside {3'd1, 3'd2, 3'd3})
			scalar_sel1_o = instruction_i.fmt_a.mask;	// s2 busy with the scalar operand
	end

	always_comb
	begin
		if (is_scalar_store)
			scalar_sel2_o = instruction_i.fmt_c.dest;	// store value
		else if (is_fmt_a && !a_type[2])
			scalar_sel2_o = instruction_i.fmt_a.src2;
		else
			scalar_sel2_o = instruction_i.fmt_a.mask;
	end

	assign vector_sel1_o = instruction_i.fmt_a.src1;

	always_comb
	begin
		if (is_fmt_a && a_type inside {3'd4, 3'd5, 3'd6})
			vector_sel2_o = instruction_i.fmt_a.src2;	// vector/vector
		else
			vector_sel2_o = instruction_i.fmt_c.dest;	// store value
	end

	always_comb
	begin
		decoded_nxt = '0;
		decoded_nxt.instruction = instruction_i;
		decoded_nxt.pc          = pc_i;
		decoded_nxt.lane_select = lane_select_i;

		// immediate sign extended by format
		if (is_fmt_b)
			decoded_nxt.immediate = {{23{instruction_i.fmt_b.imm[8]}}, instruction_i.fmt_b.imm};
		else if (is_fmt_c || is_fmt_d)
			decoded_nxt.immediate = {{22{instruction_i.fmt_c.imm[9]}}, instruction_i.fmt_c.imm};
		else
			decoded_nxt.immediate = {{11{instruction_i.fmt_e.imm[20]}}, instruction_i.fmt_e.imm};

		// op1 from v1 or s1
		if (is_fmt_a)
			decoded_nxt.op1_is_vector = a_type != 3'd0;
		else if (is_fmt_b)
			decoded_nxt.op1_is_vector = b_type != 2'd0;
		else if (is_fmt_c)
			decoded_nxt.op1_is_vector = c_op_type >= C_OP_GATHER;	// vector of addresses

		if (is_fmt_a)
			decoded_nxt.op2_src = a_type[2] ? OP2_VECTOR : OP2_SCALAR;
		else
			decoded_nxt.op2_src = OP2_IMM;

		// mask source
		if (is_fmt_a)
		begin
			case (a_type)
				3'd0: decoded_nxt.mask_src = MASK_ALL;		// scalar/scalar
				3'd1: decoded_nxt.mask_src = MASK_ALL;		// vector/scalar
				3'd2: decoded_nxt.mask_src = MASK_S1;
				3'd3: decoded_nxt.mask_src = MASK_S1_INV;
				3'd4: decoded_nxt.mask_src = MASK_ALL;		// vector/vector
				3'd5: decoded_nxt.mask_src = MASK_S2;
				3'd6: decoded_nxt.mask_src = MASK_S2_INV;
				default: decoded_nxt.mask_src = MASK_S1;	// type 7 reserved
			endcase
		end
		else if (is_fmt_b)
		begin
			case (b_type)
				2'd2: decoded_nxt.mask_src = MASK_S2;
				2'd3: decoded_nxt.mask_src = MASK_S2_INV;
				default: decoded_nxt.mask_src = MASK_ALL;	// unmasked
			endcase
		end
		else if (is_fmt_c)
		begin
			case (c_op_type)
				4'd8, 4'd11, 4'd14: decoded_nxt.mask_src = MASK_S2;
				4'd9, 4'd12, 4'd15: decoded_nxt.mask_src = MASK_S2_INV;
				default: decoded_nxt.mask_src = MASK_ALL;
			endcase
		end
		else
			decoded_nxt.mask_src = MASK_ALL;

		decoded_nxt.store_value_is_vector = !(is_fmt_c && !is_vec_xfer);

		// memory ops add the offset
		if (is_fmt_a)
			decoded_nxt.alu_op = a_opcode;
		else if (is_fmt_b)
			decoded_nxt.alu_op = {1'b0, b_opcode};
		else
			decoded_nxt.alu_op = ALU_OP_ADD;

		// no writeback for the all zero word
		decoded_nxt.has_writeback = (is_fmt_a || is_fmt_b
			|| (is_fmt_c && instruction_i.fmt_c.is_load)) && instruction_i != '0;
		decoded_nxt.writeback_reg = instruction_i.fmt_a.dest;
		if (is_fmt_a)
			decoded_nxt.writeback_is_vector = !a_is_compare && a_type != 3'd0;
		else if (is_fmt_b)
			decoded_nxt.writeback_is_vector = !b_is_compare && b_type != 2'd0;
		else if (is_fmt_c)
			decoded_nxt.writeback_is_vector = is_vec_xfer;
	end

	// flush turns the pipeline register into a bubble
	always_ff @(posedge clk)
	begin
		if (!rst_n_i || flush_i)
			decoded_o <= '0;
		else
			decoded_o <= decoded_nxt;
	end

	// bubble seen one cycle after the flush
	a_flush_clears: assert property (@(posedge clk) flush_i |=> decoded_o == '0);

	a_mask_src_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		decoded_o.mask_src <= MASK_ALL);

endmodule

`default_nettype wire

/* operand_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_fetch_top
	import isa_pkg::*;
	import core_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n_i,
	input  wire instr_word_t instruction_i,
	input  wire word_t       pc_i,
	input  wire lane_sel_t   lane_select_i,
	input  wire              flush_i,
	input  wire              wb_en_i,
	input  wire writeback_t  wb_i,
	output decoded_t         decoded_o,
	output word_t            scalar1_o,
	output word_t            scalar2_o,
	output vector_t          vector1_o,
	output vector_t          vector2_o
);

	reg_addr_t scalar_sel1;	// comb from decode, same cycle as the word
	reg_addr_t scalar_sel2;
	reg_addr_t vector_sel1;
	reg_addr_t vector_sel2;

	decode_stage decode0 (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.instruction_i (instruction_i),
		.pc_i          (pc_i),
		.lane_select_i (lane_select_i),
		.flush_i       (flush_i),
		.scalar_sel1_o (scalar_sel1),
		.scalar_sel2_o (scalar_sel2),
		.vector_sel1_o (vector_sel1),
		.vector_sel2_o (vector_sel2),
		.decoded_o     (decoded_o)
	);

	// writeback goes to one file only, by is_vector
	scalar_reg_file scalar_rf0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rd_addr1_i (scalar_sel1),
		.rd_addr2_i (scalar_sel2),
		.rd_data1_o (scalar1_o),
		.rd_data2_o (scalar2_o),
		.wr_en_i    (wb_en_i && !wb_i.is_vector),
		.wr_addr_i  (wb_i.reg_addr),
		.wr_data_i  (wb_i.scalar_value)
	);

	vector_reg_file vector_rf0 (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.rd_addr1_i     (vector_sel1),
		.rd_addr2_i     (vector_sel2),
		.rd_data1_o     (vector1_o),
		.rd_data2_o     (vector2_o),
		.wr_en_i        (wb_en_i && wb_i.is_vector),
		.wr_addr_i      (wb_i.reg_addr),
		.wr_lane_mask_i (wb_i.lane_mask),
		.wr_data_i      (wb_i.vector_value)
	);

endmodule

`default_nettype wire

/* tb_operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_operand_fetch
	import isa_pkg::*;
	import core_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 8;
	localparam int FILL_CYCLES  = 2 * NUM_REGS + 1;	// one write per cycle into both files
	// two cycles per issued word or single write
	localparam int TEST_CYCLES  = 4 + 14 + 22 + 10 + 14 + 6;
	localparam int MARGIN       = 40;

	logic        clk = 1'b0;
	logic        rst_n;
	instr_word_t instruction;
	word_t       pc;
	lane_sel_t   lane_select;
	logic        flush;
	logic        wb_en;
	writeback_t  wb;
	decoded_t    decoded;
	word_t       scalar1;
	word_t       scalar2;
	vector_t     vector1;
	vector_t     vector2;

	word_t   sreg_model [NUM_REGS];	// expected file contents
	vector_t vreg_model [NUM_REGS];
	int      err_count;
	int      check_count;
	int      tests_passed;
	int      tests_failed;
	int      test_errs_start;	// errors before the running test

	operand_fetch_top dut0 (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.instruction_i (instruction),
		.pc_i          (pc),
		.lane_select_i (lane_select),
		.flush_i       (flush),
		.wb_en_i       (wb_en),
		.wb_i          (wb),
		.decoded_o     (decoded),
		.scalar1_o     (scalar1),
		.scalar2_o     (scalar2),
		.vector1_o     (vector1),
		.vector2_o     (vector2)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// watchdog
	initial
	begin
		#(CLK_PERIOD * (RESET_CYCLES + FILL_CYCLES + TEST_CYCLES + MARGIN));
		$display("watchdog expired, the tests did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic compare_decoded(input string what, input decoded_t act, input decoded_t exp);
		check_count++;
		if (act !== exp)
		begin
			err_count++;
			$display("ERROR decoded_o (%s): got %h, expected %h", what, act, exp);
		end
	endtask

	task automatic compare_word(input string name, input word_t act, input word_t exp);
		check_count++;
		if (act !== exp)
		begin
			err_count++;
			$display("ERROR %s: got %h, expected %h", name, act, exp);
		end
	endtask

	task automatic compare_vector(input string name, input vector_t act, input vector_t exp);
		check_count++;
		if (act !== exp)
		begin
			err_count++;
			$display("ERROR %s: got %h, expected %h", name, act, exp);
		end
	endtask

	task automatic end_test(input string name);
		if (err_count == test_errs_start)
		begin
			tests_passed++;
			$display("%s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, err_count - test_errs_start);
		end
		test_errs_start = err_count;
	endtask

	// word layouts straight from the format tables
	function automatic word_t reg_reg_word(input logic [5:0] opcode, input logic [2:0] a_type,
		input reg_addr_t src2, input reg_addr_t mask, input reg_addr_t dest,
		input reg_addr_t src1);
		return {3'b110, opcode, a_type, src2, mask, dest, src1};
	endfunction

	function automatic word_t reg_imm_word(input logic [4:0] opcode, input logic [1:0] b_type,
		input logic [8:0] imm, input reg_addr_t mask, input reg_addr_t dest,
		input reg_addr_t src1);
		return {1'b0, opcode, b_type, imm, mask, dest, src1};
	endfunction

	function automatic word_t mem_word(input logic is_load, input logic [3:0] op_type,
		input logic [9:0] imm, input reg_addr_t mask, input reg_addr_t dest,
		input reg_addr_t src1);
		return {2'b10, is_load, op_type, imm, mask, dest, src1};
	endfunction

	function automatic word_t long_imm_word(input logic [20:0] imm, input reg_addr_t src1);
		return {6'b111100, imm, src1};	// format e
	endfunction

	function automatic word_t sign_extend(input word_t field, input int width);
		word_t res;
		res = field;
		for (int i = width; i < WORD_W; i++)
			res[i] = field[width-1];
		return res;
	endfunction

	// common part of every expected decode without writeback
	function automatic decoded_t expect_base(input word_t w, input word_t pc_val,
		input lane_sel_t lane_val);
		decoded_t d;
		d = '0;
		d.instruction = w;
		d.pc          = pc_val;
		d.lane_select = lane_val;
		d.op2_src     = OP2_IMM;	// all but format a
		d.mask_src    = MASK_ALL;
		d.writeback_reg = w[9:5];	// dest field
		d.store_value_is_vector = 1'b1;
		return d;
	endfunction

	// present one word and return just after the edge that registers it
	task automatic issue(input word_t w, input word_t pc_val, input lane_sel_t lane_val,
		input logic flush_val);
		@(posedge clk);
		instruction <= w;
		pc          <= pc_val;
		lane_select <= lane_val;
		flush       <= flush_val;
		@(posedge clk);
		#1;
	endtask

	task automatic check_operands(input reg_addr_t s1, input reg_addr_t s2,
		input reg_addr_t v1, input reg_addr_t v2);
		compare_word("scalar1_o", scalar1, sreg_model[s1]);
		compare_word("scalar2_o", scalar2, sreg_model[s2]);
		compare_vector("vector1_o", vector1, vreg_model[v1]);
		compare_vector("vector2_o", vector2, vreg_model[v2]);
	endtask

	task automatic write_scalar(input reg_addr_t addr, input word_t value);
		writeback_t w;
		w = '0;
		w.reg_addr     = addr;
		w.scalar_value = value;
		@(posedge clk);
		wb_en <= 1'b1;
		wb    <= w;
		@(posedge clk);	// committed here
		wb_en <= 1'b0;
		sreg_model[addr] = value;
	endtask

	task automatic write_vector(input reg_addr_t addr, input lane_mask_t mask,
		input vector_t value);
		writeback_t w;
		w = '0;
		w.is_vector    = 1'b1;
		w.reg_addr     = addr;
		w.lane_mask    = mask;
		w.vector_value = value;
		@(posedge clk);
		wb_en <= 1'b1;
		wb    <= w;
		@(posedge clk);
		wb_en <= 1'b0;
		for (int l = 0; l < NUM_LANES; l++)
			if (mask[l])
				vreg_model[addr][l] = value[l];	// other lanes keep old data
	endtask

	// random contents in every register of both files
	task automatic fill_registers();
		writeback_t w;
		for (int i = 0; i < 2 * NUM_REGS; i++)
		begin
			w = '0;
			w.is_vector    = i >= NUM_REGS;
			w.reg_addr     = reg_addr_t'(i % NUM_REGS);
			w.lane_mask    = '1;
			w.scalar_value = $urandom;
			for (int l = 0; l < NUM_LANES; l++)
				w.vector_value[l] = $urandom;
			@(posedge clk);
			wb_en <= 1'b1;
			wb    <= w;
			if (w.is_vector)
				vreg_model[w.reg_addr] = w.vector_value;
			else
				sreg_model[w.reg_addr] = w.scalar_value;
		end
		@(posedge clk);
		wb_en <= 1'b0;
	endtask

	task automatic reset_and_flush();
		word_t w;
		compare_decoded("after reset", decoded, '0);
		w = reg_imm_word(5'h03, 2'd1, 9'h044, 5'd1, 5'd2, 5'd3);
		issue(w, 32'h0000_1000, 4'd3, 1'b1);
		compare_decoded("flush", decoded, '0);
		issue(w, 32'h0000_1004, 4'd3, 1'b0);
		check_count++;
		if (decoded == '0)
		begin
			err_count++;
			$display("decoded_o stayed all zero after the flush was released");
		end
		end_test("reset_and_flush");
	endtask

	task automatic reg_write_read();
		word_t      sval;
		vector_t    vval;
		word_t      old_val;
		word_t      w;
		writeback_t wbv;
		sval = $urandom;
		write_scalar(5'd5, sval);
		write_scalar(5'd6, ~sval);
		w = reg_imm_word(5'h01, 2'd0, 9'h000, 5'd6, 5'd7, 5'd5);	// s1 = r5, s2 = r6
		issue(w, 32'h0000_2000, 4'd1, 1'b0);
		compare_word("scalar1_o", scalar1, sval);
		compare_word("scalar2_o", scalar2, ~sval);
		for (int l = 0; l < NUM_LANES; l++)
			vval[l] = $urandom;
		write_vector(5'd7, 16'h00F0, vval);	// lanes 4..7 only
		issue(w, 32'h0000_2004, 4'd2, 1'b0);
		check_operands(5'd5, 5'd6, 5'd5, 5'd7);	// v2 reads the dest field

		// write and read r5 in the same cycle
		old_val = sreg_model[5];
		wbv = '0;
		wbv.reg_addr     = 5'd5;
		wbv.scalar_value = 32'h5A5A_0005;
		@(posedge clk);
		wb_en       <= 1'b1;
		wb          <= wbv;
		instruction <= w;
		@(posedge clk);
		wb_en <= 1'b0;
		#1;
		compare_word("scalar1_o", scalar1, old_val);	// no bypass
		sreg_model[5] = wbv.scalar_value;
		issue(w, 32'h0000_2008, 4'd3, 1'b0);
		compare_word("scalar1_o", scalar1, 32'h5A5A_0005);
		end_test("reg_write_read");
	endtask

	task automatic reg_reg_case(input logic [5:0] opcode, input logic [2:0] a_type,
		input logic is_compare);
		mask_src_t mask_tbl [8];
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rmask;
		reg_addr_t rdest;
		word_t     w;
		word_t     pc_val;
		lane_sel_t lane_val;
		decoded_t  exp;
		mask_tbl = '{MASK_ALL, MASK_ALL, MASK_S1, MASK_S1_INV,
			MASK_ALL, MASK_S2, MASK_S2_INV, MASK_S1};
		rs1   = {2'b00, a_type};	// four distinct registers per type
		rs2   = rs1 + 5'd8;
		rmask = rs1 + 5'd16;
		rdest = rs1 + 5'd24;
		w = reg_reg_word(opcode, a_type, rs2, rmask, rdest, rs1);
		pc_val   = $urandom;
		lane_val = lane_sel_t'($urandom);
		exp = expect_base(w, pc_val, lane_val);
		exp.immediate     = sign_extend({11'd0, w[25:5]}, 21);
		exp.mask_src      = mask_tbl[a_type];
		exp.op1_is_vector = a_type != 3'd0;
		exp.op2_src       = a_type[2] ? OP2_VECTOR : OP2_SCALAR;
		exp.has_writeback = 1'b1;
		exp.writeback_is_vector = !is_compare && a_type != 3'd0;
		exp.alu_op        = opcode;
		issue(w, pc_val, lane_val, 1'b0);
		compare_decoded($sformatf("format a type %0d opcode %h", a_type, opcode), decoded, exp);
		check_operands(a_type inside {3'd1, 3'd2, 3'd3} ? rmask : rs1,
			a_type <= 3'd3 ? rs2 : rmask, rs1,
			a_type inside {3'd4, 3'd5, 3'd6} ? rs2 : rdest);
	endtask

	task automatic format_a_ops();
		for (int t = 0; t < 8; t++)
			reg_reg_case(6'h03, 3'(t), 1'b0);
		reg_reg_case(6'h12, 3'd5, 1'b1);	// 01xxxx compare
		reg_reg_case(6'h2D, 3'd4, 1'b1);	// 1011xx compare
		reg_reg_case(6'h28, 3'd4, 1'b0);	// close but not a compare
		end_test("format_a_ops");
	endtask

	task automatic reg_imm_case(input logic [4:0] opcode, input logic [1:0] b_type,
		input logic [8:0] imm, input logic is_compare);
		mask_src_t mask_tbl [4];
		word_t     w;
		word_t     pc_val;
		lane_sel_t lane_val;
		decoded_t  exp;
		mask_tbl = '{MASK_ALL, MASK_ALL, MASK_S2, MASK_S2_INV};
		w = reg_imm_word(opcode, b_type, imm, 5'd14, 5'd15, 5'd13);
		pc_val   = $urandom;
		lane_val = lane_sel_t'($urandom);
		exp = expect_base(w, pc_val, lane_val);
		exp.immediate     = sign_extend({23'd0, imm}, 9);
		exp.mask_src      = mask_tbl[b_type];
		exp.op1_is_vector = b_type != 2'd0;
		exp.has_writeback = 1'b1;
		exp.writeback_is_vector = !is_compare && b_type != 2'd0;
		exp.alu_op        = {1'b0, opcode};	// zero extended
		issue(w, pc_val, lane_val, 1'b0);
		compare_decoded($sformatf("format b type %0d opcode %h", b_type, opcode), decoded, exp);
		check_operands(5'd13, 5'd14, 5'd13, 5'd15);	// s2 from mask field
	endtask

	task automatic format_b_ops();
		reg_imm_case(5'h0A, 2'd0, 9'h05A, 1'b0);
		reg_imm_case(5'h0A, 2'd1, 9'h1A5, 1'b0);	// negative imm
		reg_imm_case(5'h07, 2'd2, 9'h100, 1'b0);
		reg_imm_case(5'h07, 2'd3, 9'h0FF, 1'b0);
		reg_imm_case(5'h13, 2'd2, 9'h1F0, 1'b1);	// compare by opcode bit 4
		end_test("format_b_ops");
	endtask

	task automatic mem_case(input logic is_load, input logic [3:0] op_type,
		input logic [9:0] imm);
		logic      xfer;
		logic      scalar_store;
		word_t     w;
		word_t     pc_val;
		lane_sel_t lane_val;
		decoded_t  exp;
		xfer         = op_type[3] || op_type == 4'd7;	// block, strided, scatter/gather
		scalar_store = !is_load && !xfer;
		w = mem_word(is_load, op_type, imm, 5'd11, 5'd12, 5'd10);
		pc_val   = $urandom;
		lane_val = lane_sel_t'($urandom);
		exp = expect_base(w, pc_val, lane_val);
		exp.immediate = sign_extend({22'd0, imm}, 10);
		if (op_type inside {4'd8, 4'd11, 4'd14})
			exp.mask_src = MASK_S2;
		else if (op_type inside {4'd9, 4'd12, 4'd15})
			exp.mask_src = MASK_S2_INV;
		exp.op1_is_vector         = op_type >= 4'd13;
		exp.store_value_is_vector = xfer;
		exp.has_writeback         = is_load;
		exp.writeback_is_vector   = xfer;
		exp.alu_op                = 6'd5;	// add for the address
		issue(w, pc_val, lane_val, 1'b0);
		compare_decoded($sformatf("format c load %0d op type %0d", is_load, op_type),
			decoded, exp);
		check_operands(5'd10, scalar_store ? 5'd12 : 5'd11, 5'd10, 5'd12);
	endtask

	task automatic format_c_ops();
		mem_case(1'b0, 4'd0, 10'h1F0);	// scalar store with the value on s2
		mem_case(1'b0, 4'd7, 10'h200);	// block store
		mem_case(1'b0, 4'd14, 10'h3FF);	// scatter
		mem_case(1'b0, 4'd9, 10'h011);
		mem_case(1'b1, 4'd1, 10'h2A0);	// scalar load
		mem_case(1'b1, 4'd12, 10'h155);
		mem_case(1'b1, 4'd15, 10'h3C3);	// gather
		end_test("format_c_ops");
	endtask

	task automatic long_imm_case(input word_t w);
		word_t     pc_val;
		lane_sel_t lane_val;
		decoded_t  exp;
		pc_val   = $urandom;
		lane_val = lane_sel_t'($urandom);
		exp = expect_base(w, pc_val, lane_val);
		exp.immediate = sign_extend({11'd0, w[25:5]}, 21);
		exp.alu_op    = 6'd5;
		issue(w, pc_val, lane_val, 1'b0);
		compare_decoded($sformatf("format e word %h", w), decoded, exp);
		check_operands(w[4:0], w[14:10], w[4:0], w[9:5]);
	endtask

	task automatic zero_and_long_imm();
		issue(32'h0, 32'hFFFF_FFFC, 4'hF, 1'b0);	// nop
		compare_decoded("zero word", decoded, expect_base(32'h0, 32'hFFFF_FFFC, 4'hF));
		check_operands(5'd0, 5'd0, 5'd0, 5'd0);
		long_imm_case(long_imm_word(21'h1A_2345, 5'd9));	// negative
		long_imm_case(long_imm_word(21'h0F_0F0F, 5'd21));
		end_test("zero_and_long_imm");
	endtask

	initial
	begin
		void'($urandom(27));
		rst_n       = 1'b0;
		instruction = '0;
		pc          = '0;
		lane_select = '0;
		flush       = 1'b0;
		wb_en       = 1'b0;
		wb          = '0;
		err_count       = 0;
		check_count     = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		test_errs_start = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		#1;
		reset_and_flush();
		fill_registers();
		reg_write_read();
		format_a_ops();
		format_b_ops();
		format_c_ops();
		zero_and_long_imm();
		$display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, check_count, err_count);
		if (err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
isa_pkg.sv
core_pkg.sv
scalar_reg_file.sv
vector_reg_file.sv
decode_stage.sv
operand_fetch_top.sv
tb_operand_fetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_operand_fetch \
	-f build.f \
	-o sim_operand_fetch

output=$(./obj_dir/sim_operand_fetch)
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
